//--- src/ctrlPkg.sv
package ctrlPkg;

        localparam int opWidth = 6;                     // Opcode field of the instruction

        // Opcode values
        localparam logic [opWidth-1:0] opR     = 6'h00;
        localparam logic [opWidth-1:0] opJ     = 6'h02;
        localparam logic [opWidth-1:0] opJal   = 6'h03;
        localparam logic [opWidth-1:0] opBeq   = 6'h04;
        localparam logic [opWidth-1:0] opBne   = 6'h05;
        localparam logic [opWidth-1:0] opAddi  = 6'h08;
        localparam logic [opWidth-1:0] opAddiu = 6'h09;
        localparam logic [opWidth-1:0] opSlti  = 6'h0A;
        localparam logic [opWidth-1:0] opSltiu = 6'h0B;
        localparam logic [opWidth-1:0] opAndi  = 6'h0C;
        localparam logic [opWidth-1:0] opOri   = 6'h0D;
        localparam logic [opWidth-1:0] opXori  = 6'h0E;
        localparam logic [opWidth-1:0] opLui   = 6'h0F;
        localparam logic [opWidth-1:0] opLb    = 6'h20;
        localparam logic [opWidth-1:0] opLh    = 6'h21;
        localparam logic [opWidth-1:0] opLw    = 6'h23;
        localparam logic [opWidth-1:0] opLbu   = 6'h24;
        localparam logic [opWidth-1:0] opLhu   = 6'h25;
        localparam logic [opWidth-1:0] opSb    = 6'h28;
        localparam logic [opWidth-1:0] opSh    = 6'h29;
        localparam logic [opWidth-1:0] opSw    = 6'h2B;

        // ALU operation codes
        localparam logic [3:0] aluAdd   = 4'd0;
        localparam logic [3:0] aluSub   = 4'd1;
        localparam logic [3:0] aluR     = 4'd2;         // Funct field decides
        localparam logic [3:0] aluAddi  = 4'd3;
        localparam logic [3:0] aluAddiu = 4'd4;
        localparam logic [3:0] aluSlti  = 4'd5;
        localparam logic [3:0] aluSltiu = 4'd6;
        localparam logic [3:0] aluAndi  = 4'd7;
        localparam logic [3:0] aluOri   = 4'd8;
        localparam logic [3:0] aluXori  = 4'd9;
        localparam logic [3:0] aluLui   = 4'd10;

        // Immediate extension
        localparam logic [1:0] extArith = 2'd1;         // Sign extend
        localparam logic [1:0] extLogic = 2'd2;         // Zero extend

        // Branch conditions for pcWriteCond
        localparam logic [3:0] condNone = 4'd0;
        localparam logic [3:0] condBeq  = 4'd1;
        localparam logic [3:0] condBne  = 4'd2;

        typedef enum logic [3:0] {
                stFetch    = 4'd0,
                stDecode   = 4'd1,
                stMemAddr  = 4'd2,
                stMemRead  = 4'd3,
                stLoadWb   = 4'd4,
                stMemWrite = 4'd5,
                stRExec    = 4'd6,
                stRWb      = 4'd7,
                stBranch   = 4'd8,
                stJump     = 4'd9,
                stJal      = 4'd10,
                stImmExec  = 4'd11,
                stImmWb    = 4'd12
        } ctrlStateT;

        typedef enum logic [2:0] {
                clsIllegal = 3'd0,
                clsLoad    = 3'd1,
                clsStore   = 3'd2,
                clsR       = 3'd3,
                clsBranch  = 3'd4,
                clsJump    = 3'd5,
                clsJal     = 3'd6,
                clsImm     = 3'd7
        } instrClassT;

        typedef struct packed {
                instrClassT  instrClass;
                logic [3:0]  immAluOp;                  // Only for clsImm
                logic [1:0]  immExtOp;
                logic [3:0]  branchCond;                // Only for clsBranch
        } opInfoT;

        typedef struct packed {
                logic [3:0]  pcWriteCond;
                logic        pcWrite;
                logic        memRead;
                logic        memWrite;
                logic [1:0]  regData;                   // Write data select
                logic        irWrite;
                logic [1:0]  pcSource;
                logic [3:0]  aluOp;
                logic [1:0]  extOp;
                logic [1:0]  aluSrcA;
                logic [1:0]  aluSrcB;
                logic        regWrite;
                logic [1:0]  regDst;                    // Destination register select
                logic        iorD;                      // Memory address from ALUOut
        } ctrlWordT;

endpackage

//--- src/opDecoder.sv
module opDecoder (
        input  logic [ctrlPkg::opWidth-1:0] op,
        output ctrlPkg::opInfoT             info
);

        always_comb
        begin
                info            = '0;
                info.instrClass = ctrlPkg::clsIllegal;  // Unknown opcodes
                info.branchCond = ctrlPkg::condNone;
                case (op)
                        ctrlPkg::opLb, ctrlPkg::opLbu, ctrlPkg::opLh,
                        ctrlPkg::opLhu, ctrlPkg::opLw:
                                info.instrClass = ctrlPkg::clsLoad;
                        ctrlPkg::opSb, ctrlPkg::opSh, ctrlPkg::opSw:
                                info.instrClass = ctrlPkg::clsStore;
                        ctrlPkg::opR:
                                info.instrClass = ctrlPkg::clsR;
                        ctrlPkg::opBeq:
                        begin
                                info.instrClass = ctrlPkg::clsBranch;
                                info.branchCond = ctrlPkg::condBeq;
                        end
                        ctrlPkg::opBne:
                        begin
                                info.instrClass = ctrlPkg::clsBranch;
                                info.branchCond = ctrlPkg::condBne;
                        end
                        ctrlPkg::opJ:
                                info.instrClass = ctrlPkg::clsJump;
                        ctrlPkg::opJal:
                                info.instrClass = ctrlPkg::clsJal;
                        ctrlPkg::opAddi, ctrlPkg::opAddiu, ctrlPkg::opSlti,
                        ctrlPkg::opSltiu:
                        begin
                                info.instrClass = ctrlPkg::clsImm;
                                info.immExtOp   = ctrlPkg::extArith;
                                case (op)
                                        ctrlPkg::opAddi:  info.immAluOp = ctrlPkg::aluAddi;
                                        ctrlPkg::opAddiu: info.immAluOp = ctrlPkg::aluAddiu;
                                        ctrlPkg::opSlti:  info.immAluOp = ctrlPkg::aluSlti;
                                        default:          info.immAluOp = ctrlPkg::aluSltiu;
                                endcase
                        end
                        ctrlPkg::opAndi, ctrlPkg::opOri, ctrlPkg::opXori:
                        begin
                                info.instrClass = ctrlPkg::clsImm;
                                info.immExtOp   = ctrlPkg::extLogic;
                                case (op)
                                        ctrlPkg::opAndi: info.immAluOp = ctrlPkg::aluAndi;
                                        ctrlPkg::opOri:  info.immAluOp = ctrlPkg::aluOri;
                                        default:         info.immAluOp = ctrlPkg::aluXori;
                                endcase
                        end
                        ctrlPkg::opLui:
                        begin
                                info.instrClass = ctrlPkg::clsImm;
                                info.immAluOp   = ctrlPkg::aluLui;  // No extension needed
                        end
                        default:
                                info.instrClass = ctrlPkg::clsIllegal;
                endcase
        end

endmodule

//--- src/ctrlSequencer.sv
module ctrlSequencer (
        input  logic                clk,
        input  logic                rst,
        input  ctrlPkg::instrClassT instrClass,
        output ctrlPkg::ctrlStateT  state
);

        ctrlPkg::ctrlStateT nextState;

        always_ff @(posedge clk or posedge rst)
        begin
                if (rst)
                        state <= ctrlPkg::stFetch;
                else
                        state <= nextState;
        end

        // Opcode is held stable, so the class is valid in every state after fetch
        always_comb
        begin
                case (state)
                        ctrlPkg::stFetch:
                                nextState = ctrlPkg::stDecode;
                        ctrlPkg::stDecode:
                        begin
                                case (instrClass)
                                        ctrlPkg::clsLoad,
                                        ctrlPkg::clsStore:  nextState = ctrlPkg::stMemAddr;
                                        ctrlPkg::clsR:      nextState = ctrlPkg::stRExec;
                                        ctrlPkg::clsBranch: nextState = ctrlPkg::stBranch;
                                        ctrlPkg::clsJump:   nextState = ctrlPkg::stJump;
                                        ctrlPkg::clsJal:    nextState = ctrlPkg::stJal;
                                        ctrlPkg::clsImm:    nextState = ctrlPkg::stImmExec;
                                        default:            nextState = ctrlPkg::stFetch;
                                endcase
                        end
                        ctrlPkg::stMemAddr:
                        begin
                                if (instrClass == ctrlPkg::clsLoad)
                                        nextState = ctrlPkg::stMemRead;
                                else
                                        nextState = ctrlPkg::stMemWrite;
                        end
                        ctrlPkg::stMemRead:
                                nextState = ctrlPkg::stLoadWb;
                        ctrlPkg::stRExec:
                                nextState = ctrlPkg::stRWb;
                        ctrlPkg::stImmExec:
                                nextState = ctrlPkg::stImmWb;
                        default:
                                nextState = ctrlPkg::stFetch;   // Last step of every instruction
                endcase
        end

endmodule

//--- src/ctrlSignalDecoder.sv
module ctrlSignalDecoder (
        input  ctrlPkg::ctrlStateT state,
        input  logic [3:0]         immAluOp,
        input  logic [1:0]         immExtOp,
        input  logic [3:0]         branchCond,
        output ctrlPkg::ctrlWordT  ctrl
);

        always_comb
        begin
                ctrl = '0;                              // Unlisted fields stay low
                case (state)
                        ctrlPkg::stFetch:
                        begin
                                ctrl.pcWrite = 1'b1;
                                ctrl.memRead = 1'b1;
                                ctrl.irWrite = 1'b1;
                                ctrl.aluOp   = ctrlPkg::aluAdd;  // PC + 4
                                ctrl.aluSrcB = 2'd1;
                        end
                        ctrlPkg::stDecode:
                        begin
                                ctrl.aluOp   = ctrlPkg::aluAdd;  // Branch target precompute
                                ctrl.aluSrcB = 2'd3;
                        end
                        ctrlPkg::stMemAddr:
                        begin
                                ctrl.aluSrcA = 2'd1;
                                ctrl.aluSrcB = 2'd2;    // Base plus offset
                        end
                        ctrlPkg::stMemRead:
                        begin
                                ctrl.memRead = 1'b1;
                                ctrl.iorD    = 1'b1;
                        end
                        ctrlPkg::stLoadWb:
                        begin
                                ctrl.memRead  = 1'b1;
                                ctrl.regData  = 2'd1;   // Memory data register
                                ctrl.regWrite = 1'b1;
                        end
                        ctrlPkg::stMemWrite:
                        begin
                                ctrl.memWrite = 1'b1;
                                ctrl.iorD     = 1'b1;
                        end
                        ctrlPkg::stRExec:
                        begin
                                ctrl.aluOp   = ctrlPkg::aluR;
                                ctrl.aluSrcA = 2'd1;
                        end
                        ctrlPkg::stRWb:
                        begin
                                // Non-R ALU code clears the funct-driven ALU control
                                ctrl.pcSource = 2'd1;
                                ctrl.aluOp    = ctrlPkg::aluOri;
                                ctrl.regWrite = 1'b1;
                                ctrl.regDst   = 2'd1;   // rd
                        end
                        ctrlPkg::stBranch:
                        begin
                                ctrl.pcWriteCond = branchCond;
                                ctrl.pcSource    = 2'd1;
                                ctrl.aluOp       = ctrlPkg::aluSub;  // Compare rs and rt
                                ctrl.aluSrcA     = 2'd1;
                        end
                        ctrlPkg::stJump:
                        begin
                                ctrl.pcWrite  = 1'b1;
                                ctrl.pcSource = 2'd2;   // Jump target
                        end
                        ctrlPkg::stJal:
                        begin
                                ctrl.pcWrite  = 1'b1;
                                ctrl.pcSource = 2'd2;
                                ctrl.regData  = 2'd3;   // Return address
                                ctrl.regWrite = 1'b1;
                                ctrl.regDst   = 2'd3;   // Link register
                        end
                        ctrlPkg::stImmExec:
                        begin
                                ctrl.aluOp   = immAluOp;
                                ctrl.extOp   = immExtOp;
                                ctrl.aluSrcA = 2'd1;
                                ctrl.aluSrcB = 2'd2;    // Extended immediate
                        end
                        ctrlPkg::stImmWb:
                                ctrl.regWrite = 1'b1;   // rt from ALUOut
                        default:
                                ctrl = '0;
                endcase
        end

endmodule

//--- src/ctrlUnit.sv
module ctrlUnit (
        input  logic                        clk,
        input  logic                        rst,
        input  logic [ctrlPkg::opWidth-1:0] op,
        output ctrlPkg::ctrlWordT           ctrl,
        output ctrlPkg::ctrlStateT          state
);

        ctrlPkg::opInfoT info;                          // Decoded opcode fields

        opDecoder u_opDecoder (
                .op   (op),
                .info (info)
        );

        ctrlSequencer u_ctrlSequencer (
                .clk        (clk),
                .rst        (rst),
                .instrClass (info.instrClass),
                .state      (state)
        );

        ctrlSignalDecoder u_ctrlSignalDecoder (
                .state      (state),
                .immAluOp   (info.immAluOp),
                .immExtOp   (info.immExtOp),
                .branchCond (info.branchCond),
                .ctrl       (ctrl)
        );

endmodule

//--- verif/ctrlUnit_checker.sv
module ctrlUnit_checker (
        input logic               clk,
        input logic               rst,
        input ctrlPkg::ctrlStateT state,
        input ctrlPkg::ctrlWordT  ctrl,
        input ctrlPkg::opInfoT    info
);

        int failCount = 0;                              // Failed assertions so far

        memExclusive: assert property (@(posedge clk) disable iff (rst)
                !(ctrl.memRead && ctrl.memWrite))
        else
        begin
                failCount++;
                $error("memRead and memWrite are high together");
        end

        irWriteInFetch: assert property (@(posedge clk) disable iff (rst)
                ctrl.irWrite |-> state == ctrlPkg::stFetch)
        else
        begin
                failCount++;
                $error("irWrite is high outside stFetch");
        end

        // Decode only precomputes the branch target
        decodeNoWrite: assert property (@(posedge clk) disable iff (rst)
                state == ctrlPkg::stDecode |-> !(ctrl.regWrite || ctrl.pcWrite))
        else
        begin
                failCount++;
                $error("regWrite or pcWrite is high in stDecode");
        end

        illegalToFetch: assert property (@(posedge clk) disable iff (rst)
                (state == ctrlPkg::stDecode && info.instrClass == ctrlPkg::clsIllegal)
                |=> state == ctrlPkg::stFetch)
        else
        begin
                failCount++;
                $error("Illegal opcode did not return to stFetch after stDecode");
        end

endmodule

//--- verif/ctrlUnitTb.sv
module ctrlUnitTb;

        localparam int clkPeriod = 4;
        localparam int numInstr  = 400;
        localparam int timeLimit = numInstr * 5 * clkPeriod + 50 * clkPeriod;  // Plus reset

        localparam logic [5:0] keptOps [21] = '{
                ctrlPkg::opR, ctrlPkg::opJ, ctrlPkg::opJal, ctrlPkg::opBeq, ctrlPkg::opBne,
                ctrlPkg::opAddi, ctrlPkg::opAddiu, ctrlPkg::opSlti, ctrlPkg::opSltiu,
                ctrlPkg::opAndi, ctrlPkg::opOri, ctrlPkg::opXori, ctrlPkg::opLui,
                ctrlPkg::opLb, ctrlPkg::opLh, ctrlPkg::opLw, ctrlPkg::opLbu, ctrlPkg::opLhu,
                ctrlPkg::opSb, ctrlPkg::opSh, ctrlPkg::opSw
        };

        logic                        clk = 1'b0;
        logic                        rst;
        logic [ctrlPkg::opWidth-1:0] op;
        ctrlPkg::ctrlWordT           ctrl;
        ctrlPkg::ctrlStateT          state;

        ctrlPkg::ctrlStateT  modelState;
        ctrlPkg::instrClassT modelCls;
        int                  errorCount = 0;
        int                  checkCount = 0;
        int                  cycleCount;                // DUT cycles of this instruction
        int                  instrCount;

        always #(clkPeriod / 2) clk = ~clk;

        ctrlUnit u_ctrlUnit (
                .clk   (clk),
                .rst   (rst),
                .op    (op),
                .ctrl  (ctrl),
                .state (state)
        );

        bind ctrlUnit ctrlUnit_checker u_checker (
                .clk   (clk),
                .rst   (rst),
                .state (state),
                .ctrl  (ctrl),
                .info  (info)
        );

        function automatic ctrlPkg::instrClassT classOf(logic [5:0] opcode);
                if (opcode inside {[ctrlPkg::opAddi:ctrlPkg::opLui]})
                        return ctrlPkg::clsImm;
                case (opcode)
                        ctrlPkg::opLb, ctrlPkg::opLh, ctrlPkg::opLw,
                        ctrlPkg::opLbu, ctrlPkg::opLhu:              return ctrlPkg::clsLoad;
                        ctrlPkg::opSb, ctrlPkg::opSh, ctrlPkg::opSw: return ctrlPkg::clsStore;
                        ctrlPkg::opR:                                return ctrlPkg::clsR;
                        ctrlPkg::opBeq, ctrlPkg::opBne:              return ctrlPkg::clsBranch;
                        ctrlPkg::opJ:                                return ctrlPkg::clsJump;
                        ctrlPkg::opJal:                              return ctrlPkg::clsJal;
                        default:                                     return ctrlPkg::clsIllegal;
                endcase
        endfunction

        function automatic ctrlPkg::ctrlStateT nextStateOf(ctrlPkg::ctrlStateT st,
                                                           ctrlPkg::instrClassT cls);
                if (st == ctrlPkg::stFetch)
                        return ctrlPkg::stDecode;
                if (st == ctrlPkg::stDecode)
                begin
                        case (cls)
                                ctrlPkg::clsLoad, ctrlPkg::clsStore: return ctrlPkg::stMemAddr;
                                ctrlPkg::clsR:                       return ctrlPkg::stRExec;
                                ctrlPkg::clsBranch:                  return ctrlPkg::stBranch;
                                ctrlPkg::clsJump:                    return ctrlPkg::stJump;
                                ctrlPkg::clsJal:                     return ctrlPkg::stJal;
                                ctrlPkg::clsImm:                     return ctrlPkg::stImmExec;
                                default:                             return ctrlPkg::stFetch;
                        endcase
                end
                if (st == ctrlPkg::stMemAddr)
                        return (cls == ctrlPkg::clsLoad) ? ctrlPkg::stMemRead : ctrlPkg::stMemWrite;
                if (st == ctrlPkg::stMemRead)
                        return ctrlPkg::stLoadWb;
                if (st == ctrlPkg::stRExec)
                        return ctrlPkg::stRWb;
                if (st == ctrlPkg::stImmExec)
                        return ctrlPkg::stImmWb;
                return ctrlPkg::stFetch;
        endfunction

        function automatic int cyclesOf(ctrlPkg::instrClassT cls);
                case (cls)
                        ctrlPkg::clsLoad:                      return 5;
                        ctrlPkg::clsStore, ctrlPkg::clsR,
                        ctrlPkg::clsImm:                       return 4;
                        ctrlPkg::clsIllegal:                   return 2;
                        default:                               return 3;
                endcase
        endfunction

        // Built field by field from the per-state rules
        function automatic ctrlPkg::ctrlWordT expectedCtrl(ctrlPkg::ctrlStateT st,
                                                           logic [5:0] opcode);
                ctrlPkg::ctrlWordT w;
                logic              isArith;
                logic              isLogic;
                w          = '0;
                isArith    = opcode inside {ctrlPkg::opAddi, ctrlPkg::opAddiu,
                                            ctrlPkg::opSlti, ctrlPkg::opSltiu};
                isLogic    = opcode inside {ctrlPkg::opAndi, ctrlPkg::opOri, ctrlPkg::opXori};
                w.pcWrite  = st inside {ctrlPkg::stFetch, ctrlPkg::stJump, ctrlPkg::stJal};
                w.memRead  = st inside {ctrlPkg::stFetch, ctrlPkg::stMemRead, ctrlPkg::stLoadWb};
                w.memWrite = st == ctrlPkg::stMemWrite;
                w.irWrite  = st == ctrlPkg::stFetch;
                w.iorD     = st inside {ctrlPkg::stMemRead, ctrlPkg::stMemWrite};
                w.regWrite = st inside {ctrlPkg::stLoadWb, ctrlPkg::stRWb,
                                        ctrlPkg::stJal, ctrlPkg::stImmWb};
                w.regData  = (st == ctrlPkg::stJal) ? 2'd3 : (st == ctrlPkg::stLoadWb) ? 2'd1 : 2'd0;
                w.regDst   = (st == ctrlPkg::stJal) ? 2'd3 : (st == ctrlPkg::stRWb) ? 2'd1 : 2'd0;
                w.pcSource = (st inside {ctrlPkg::stJump, ctrlPkg::stJal}) ? 2'd2 :
                             (st inside {ctrlPkg::stRWb, ctrlPkg::stBranch}) ? 2'd1 : 2'd0;
                w.aluSrcA  = (st inside {ctrlPkg::stMemAddr, ctrlPkg::stRExec,
                                         ctrlPkg::stBranch, ctrlPkg::stImmExec}) ? 2'd1 : 2'd0;
                w.aluSrcB  = (st == ctrlPkg::stFetch) ? 2'd1 : (st == ctrlPkg::stDecode) ? 2'd3 :
                             (st inside {ctrlPkg::stMemAddr, ctrlPkg::stImmExec}) ? 2'd2 : 2'd0;
                if (st == ctrlPkg::stRExec)
                        w.aluOp = ctrlPkg::aluR;
                else if (st == ctrlPkg::stRWb)
                        w.aluOp = ctrlPkg::aluOri;
                else if (st == ctrlPkg::stBranch)
                begin
                        w.aluOp       = ctrlPkg::aluSub;
                        w.pcWriteCond = (opcode == ctrlPkg::opBne) ? ctrlPkg::condBne
                                                                   : ctrlPkg::condBeq;
                end
                else if (st == ctrlPkg::stImmExec)
                begin
                        // Immediate opcodes and their ALU codes run in the same order
                        w.aluOp = 4'(opcode - ctrlPkg::opAddi) + ctrlPkg::aluAddi;
                        w.extOp = isArith ? ctrlPkg::extArith : isLogic ? ctrlPkg::extLogic : 2'd0;
                end
                return w;
        endfunction

        function automatic logic [5:0] pickOp();
                logic [5:0] v;
                int         idx;
                if ($urandom_range(99) < 80)
                begin
                        idx = $urandom_range(20);
                        return keptOps[idx];
                end
                do
                        v = 6'($urandom_range(63));
                while (classOf(v) != ctrlPkg::clsIllegal);
                return v;
        endfunction

        task automatic compareValue(input string name, input logic [31:0] expected,
                                    input logic [31:0] actual);
                checkCount++;
                if (expected !== actual)
                begin
                        errorCount++;
                        $display("FAILED %s: expected %h, actual %h", name, expected, actual);
                end
        endtask

        task automatic checkCycle(input string tag);
                compareValue($sformatf("%s %s state", tag, modelState.name()),
                             32'(modelState), 32'(state));
                compareValue($sformatf("%s %s ctrl", tag, modelState.name()),
                             32'(expectedCtrl(modelState, op)), 32'(ctrl));
        endtask

        initial
        begin
                void'($urandom(32'h7ec7_5935));
                rst        = 1'b1;
                op         = '0;
                modelState = ctrlPkg::stFetch;
                modelCls   = ctrlPkg::clsIllegal;
                repeat (3) @(posedge clk);
                @(negedge clk);
                checkCycle("reset");
                @(posedge clk);
                rst        <= 1'b0;
                op         <= pickOp();
                cycleCount = 1;                         // Fetch cycle
                instrCount = 0;
                while (instrCount < numInstr)
                begin
                        @(negedge clk);                 // Outputs settled
                        modelCls = classOf(op);
                        checkCycle(modelCls.name());
                        if (state != ctrlPkg::stFetch)
                                cycleCount++;
                        @(posedge clk);
                        modelState = nextStateOf(modelState, modelCls);
                        if (modelState == ctrlPkg::stFetch)
                        begin
                                compareValue($sformatf("%s cycles", modelCls.name()),
                                             cyclesOf(modelCls), cycleCount);
                                cycleCount = 1;
                                instrCount++;
                                op <= pickOp();         // New instruction
                        end
                end
                @(negedge clk);
                $display("Checks: %0d, mismatches: %0d, assertion failures: %0d",
                         checkCount, errorCount, u_ctrlUnit.u_checker.failCount);
                if (errorCount == 0 && u_ctrlUnit.u_checker.failCount == 0)
                        $display("TESTBENCH PASSED");
                else
                        $display("TESTBENCH FAILED");
                $finish;
        end

        initial
        begin
                #(timeLimit);
                $display("Timeout: the DUT did not get through %0d instructions in time",
                         numInstr);
                $display("TESTBENCH FAILED");
                $finish;
        end

endmodule

//--- src.f
src/ctrlPkg.sv
src/opDecoder.sv
src/ctrlSequencer.sv
src/ctrlSignalDecoder.sv
src/ctrlUnit.sv
verif/ctrlUnit_checker.sv
verif/ctrlUnitTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module ctrlUnitTb -f src.f -o ctrlUnitTbSim

./obj_dir/ctrlUnitTbSim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
        exit 0
fi
exit 1
